/* bench/loader_tests.txt */
# C <index hex> <bytes dec> | R <console addr hex> <reads dec> | S <stall cycles dec>
# K <flags hex> <addr hex> <compare hex> <replace hex>
C 00 8192
R 0000 4
R 1234 3
R 1ffe 4
C 01 4608
R 0000 4
R 0e00 2
R 0dfe 4
R 1f00 3
C 42 2048
R 0005 2
R 1a05 4
R 07ff 2
K 00000001 00801234 000000ab 000000cd
S 12
K 80000003 007e0010 0000ff00 12345678
K deadbeef 0badf00d 01234567 89abcdef
S 3
K 11223344 55667788 99aabbcc ddeeff00
R 0100 6

/* bench/tb_loader.sv */
module tb_loader import loader_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int    ROM_ADDR_W = 13;
	localparam int    WRITE_WAIT = 3;
	localparam int    TIMEOUT    = 200;  // Cycles per wait loop
	localparam string TEST_FILE  = "bench/loader_tests.txt";

	logic                  clk_sys = 1'b0;
	logic                  rst;
	logic                  dl_active;
	index_t                dl_index;
	logic                  dl_valid;
	logic                  dl_ready;
	dl_addr_t              dl_addr;
	byte_t                 dl_data;
	logic                  rd_req;
	logic [ROM_ADDR_W-1:0] rd_addr;
	byte_t                 rd_data;
	logic                  rd_data_valid;
	logic                  code_valid;
	logic                  code_ready;
	word_t                 code_flags;
	word_t                 code_addr;
	word_t                 code_compare;
	word_t                 code_replace;
	logic                  handheld;

	// Reference cartridge geometry
	logic [ROM_ADDR_W-1:0] ref_mask;
	logic [ROM_ADDR_W-1:0] ref_hdr_mask;
	logic                  ref_header;

	int errors     = 0;
	int checks     = 0;
	int stall_next = 0;  // code_ready hold for the next record

	always #4 clk_sys = ~clk_sys;

	loader_top #(
		.ROM_ADDR_W (ROM_ADDR_W),
		.WRITE_WAIT (WRITE_WAIT)
	) u_dut (
		.clk_sys       (clk_sys),
		.rst           (rst),
		.dl_active     (dl_active),
		.dl_index      (dl_index),
		.dl_valid      (dl_valid),
		.dl_ready      (dl_ready),
		.dl_addr       (dl_addr),
		.dl_data       (dl_data),
		.rd_req        (rd_req),
		.rd_addr       (rd_addr),
		.rd_data       (rd_data),
		.rd_data_valid (rd_data_valid),
		.code_valid    (code_valid),
		.code_ready    (code_ready),
		.code_flags    (code_flags),
		.code_addr     (code_addr),
		.code_compare  (code_compare),
		.code_replace  (code_replace),
		.handheld      (handheld)
	);

	// ============================================================
	// Reference model and checks
	// ============================================================

	function automatic byte_t pattern_byte(input int a);
		return byte_t'(a ^ (a >> 8));
	endfunction

	// Console address to the image byte it must return
	function automatic byte_t rom_expect(input logic [ROM_ADDR_W-1:0] a);
		logic [ROM_ADDR_W-1:0] t;
		if (ref_header)
			t = (a + ROM_ADDR_W'(HEADER_BYTES)) & ref_hdr_mask;  // Skip the header
		else
			t = a & ref_mask;
		return pattern_byte(int'(t));
	endfunction

	task automatic finish_run();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	endtask

	task automatic fail_timeout(input string what);
		errors++;
		$display("Timeout while waiting for %s at %0t", what, $time);
		finish_run();
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got === exp)
		else begin
			errors++;
			$display("Error: %s is 0x%h, expected 0x%h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_record(input word_t w0, input word_t w1, input word_t w2,
		input word_t w3);
		check_value("code_flags", code_flags, w0);
		check_value("code_addr", code_addr, w1);
		check_value("code_compare", code_compare, w2);
		check_value("code_replace", code_replace, w3);
	endtask

	// ============================================================
	// Stimulus
	// ============================================================

	task automatic send_byte(input dl_addr_t a, input byte_t d);
		int gap;
		int waited;
		gap = int'($urandom % 3);
		if (gap != 0) begin
			dl_valid <= 1'b0;
			repeat (gap) @(posedge clk_sys);
		end
		dl_valid <= 1'b1;
		dl_addr  <= a;
		dl_data  <= d;
		waited = 0;
		@(negedge clk_sys);
		while (!dl_ready && waited < TIMEOUT) begin
			@(negedge clk_sys);
			waited++;
		end
		if (!dl_ready)
			fail_timeout("dl_ready");
		@(posedge clk_sys);  // Byte taken on this edge
	endtask

	task automatic load_cart(input index_t idx, input int count);
		int i;
		dl_index     <= idx;
		dl_active    <= 1'b1;
		ref_mask     = '0;
		ref_hdr_mask = '0;
		@(posedge clk_sys);
		for (i = 0; i < count; i++) begin
			send_byte(dl_addr_t'(i), pattern_byte(i));
			ref_mask = ref_mask | ROM_ADDR_W'(i);
			if (i >= HEADER_BYTES)
				ref_hdr_mask = ref_hdr_mask | ROM_ADDR_W'(i - HEADER_BYTES);
		end
		dl_valid <= 1'b0;
		@(posedge clk_sys);
		dl_active <= 1'b0;
		repeat (3) @(posedge clk_sys);
		// Odd multiple of 512 bytes
		ref_header = ((count / HEADER_BYTES) % 2) == 1;
		@(negedge clk_sys);
		check_value("handheld", 32'(handheld), 32'(idx[4:0] == HANDHELD_INDEX));
		@(posedge clk_sys);
	endtask

	// Back-to-back reads, data_valid expected exactly two cycles later
	task automatic read_burst(input logic [ROM_ADDR_W-1:0] a, input int n);
		int                    i;
		logic                  exp_v;
		logic [ROM_ADDR_W-1:0] ra;
		for (i = 0; i < n + 3; i++) begin
			rd_req  <= (i < n);
			rd_addr <= a + ROM_ADDR_W'(i);
			@(negedge clk_sys);
			exp_v = (i >= 2) && (i < n + 2);
			check_value("rd_data_valid", 32'(rd_data_valid), 32'(exp_v));
			if (exp_v) begin
				ra = a + ROM_ADDR_W'(i - 2);
				check_value($sformatf("rd_data[%h]", ra), 32'(rd_data), 32'(rom_expect(ra)));
			end
			@(posedge clk_sys);
		end
	endtask

	task automatic load_code(input word_t w0, input word_t w1, input word_t w2,
		input word_t w3);
		word_t rec [4];
		int    k;
		int    waited;
		rec[0] = w0;
		rec[1] = w1;
		rec[2] = w2;
		rec[3] = w3;
		dl_index  <= CODE_INDEX;
		dl_active <= 1'b1;
		@(posedge clk_sys);
		for (k = 0; k < CODE_BYTES; k++)
			send_byte(dl_addr_t'(k), byte_t'(rec[k / 4] >> (8 * (k % 4))));
		dl_valid <= 1'b0;
		waited = 0;
		@(negedge clk_sys);
		while (!code_valid && waited < TIMEOUT) begin
			@(negedge clk_sys);
			waited++;
		end
		if (!code_valid)
			fail_timeout("code_valid");
		check_record(w0, w1, w2, w3);
		// Held record, the next byte must bounce
		for (k = 0; k < stall_next; k++) begin
			@(posedge clk_sys);
			dl_valid <= 1'b1;
			dl_addr  <= '0;
			dl_data  <= ~w0[7:0];
			@(negedge clk_sys);
			check_value("code_valid", 32'(code_valid), 32'd1);
			check_value("dl_ready", 32'(dl_ready), 32'd0);
			check_record(w0, w1, w2, w3);
		end
		stall_next = 0;
		@(posedge clk_sys);
		dl_valid   <= 1'b0;
		code_ready <= 1'b1;
		@(posedge clk_sys);
		code_ready <= 1'b0;
		dl_active  <= 1'b0;
		@(negedge clk_sys);
		check_value("code_valid", 32'(code_valid), 32'd0);
		@(posedge clk_sys);
	endtask

	// ============================================================
	// Test file sequencer
	// ============================================================

	initial begin
		int    fd;
		int    fields;
		int    v0;
		int    v1;
		string line;
		string cmd;
		word_t w0;
		word_t w1;
		word_t w2;
		word_t w3;
		void'($urandom(32'hf89f9e86));
		rst          = 1'b1;
		dl_active    = 1'b0;
		dl_index     = '0;
		dl_valid     = 1'b0;
		dl_addr      = '0;
		dl_data      = '0;
		rd_req       = 1'b0;
		rd_addr      = '0;
		code_ready   = 1'b0;
		ref_mask     = '0;
		ref_hdr_mask = '0;
		ref_header   = 1'b0;
		repeat (16) @(posedge clk_sys);
		rst <= 1'b0;
		repeat (2) @(posedge clk_sys);
		fd = $fopen(TEST_FILE, "r");
		if (fd == 0) begin
			errors++;
			$display("Cannot open %s", TEST_FILE);
		end else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				fields = $sscanf(line, "%s", cmd);
				if (fields < 1 || cmd.getc(0) == "#") begin
					// Blank or comment line
				end else if (cmd == "C") begin
					void'($sscanf(line, "%s %h %d", cmd, v0, v1));
					load_cart(index_t'(v0), v1);
				end else if (cmd == "R") begin
					void'($sscanf(line, "%s %h %d", cmd, v0, v1));
					read_burst(ROM_ADDR_W'(v0), v1);
				end else if (cmd == "K") begin
					void'($sscanf(line, "%s %h %h %h %h", cmd, w0, w1, w2, w3));
					load_code(w0, w1, w2, w3);
				end else if (cmd == "S") begin
					void'($sscanf(line, "%s %d", cmd, v0));
					stall_next = v0;
				end else begin
					errors++;
					$display("Unknown command %s in %s", cmd, TEST_FILE);
				end
			end
			$fclose(fd);
		end
		if (checks == 0) begin
			errors++;
			$display("No checks were run");
		end
		finish_run();
	end

endmodule

/* logic/cart_geometry.sv */
module cart_geometry import loader_pkg::*; #(
	parameter int ROM_ADDR_W = 13
) (
	input  logic                  clk_sys,
	input  logic                  rst,
	input  logic                  dl_active,
	input  logic                  cart_beat,
	input  dl_addr_t              beat_addr,
	input  logic                  rd_req,
	input  logic [ROM_ADDR_W-1:0] rd_addr,
	rom_rd_if.master              rom_rd
);
	localparam int                    HDR_BIT = $clog2(HEADER_BYTES);
	localparam logic [ROM_ADDR_W-1:0] HDR_OFS = ROM_ADDR_W'(HEADER_BYTES);
	localparam dl_addr_t              HDR_ADDR = dl_addr_t'(HEADER_BYTES);

	logic [ROM_ADDR_W-1:0] mask;        // Main mask
	logic [ROM_ADDR_W-1:0] hdr_mask;    // Mask behind the header
	logic [ROM_ADDR_W-1:0] xlat_addr;
	dl_addr_t              hdr_rel;
	dl_addr_t              end_addr;    // One past the last cartridge byte
	logic                  active_q;
	logic                  has_header;

	// ============================================================
	// Geometry learning
	// ============================================================

	assign hdr_rel = beat_addr - HDR_ADDR;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			mask       <= '0;
			hdr_mask   <= '0;
			end_addr   <= '0;
			active_q   <= 1'b0;
			has_header <= 1'b0;
		end else begin
			active_q <= dl_active;
			if (cart_beat) begin
				end_addr <= beat_addr + dl_addr_t'(1);
				if (beat_addr == '0)
					mask <= '0;  // New image
				else
					mask <= mask | beat_addr[ROM_ADDR_W-1:0];
				if (beat_addr == HDR_ADDR)
					hdr_mask <= '0;
				else if (beat_addr > HDR_ADDR)
					hdr_mask <= hdr_mask | hdr_rel[ROM_ADDR_W-1:0];
			end
			// Image size an odd multiple of 512 means a header is present
			if (active_q && !dl_active)
				has_header <= end_addr[HDR_BIT];
		end
	end

	// ============================================================
	// Console read translation
	// ============================================================

	assign xlat_addr = has_header ? ((rd_addr + HDR_OFS) & hdr_mask) : (rd_addr & mask);

	always_ff @(posedge clk_sys) begin
		if (rst)
			rom_rd.req <= 1'b0;
		else
			rom_rd.req <= rd_req;
	end

	always_ff @(posedge clk_sys) begin
		if (rd_req) rom_rd.addr <= xlat_addr;
	end

endmodule

/* logic/cheat_assembler.sv */
module cheat_assembler import loader_pkg::*; (
	input  logic    clk_sys,
	input  logic    rst,
	byte_wr_if.sink code_wr,
	output logic    code_valid,
	input  logic    code_ready,
	output word_t   code_flags,
	output word_t   code_addr,
	output word_t   code_compare,
	output word_t   code_replace
);
	localparam int OFS_W = $clog2(CODE_BYTES);
	localparam logic [OFS_W-1:0] LAST_OFS = OFS_W'(CODE_BYTES - 1);

	typedef enum logic [0:0] {
		ST_COLLECT,
		ST_HOLD
	} state_t;

	state_t state;
	byte_t  rec [CODE_BYTES];  // Record bytes by offset
	logic   beat;

	// ============================================================
	// Byte collection
	// ============================================================

	assign code_wr.ready = (state == ST_COLLECT);  // Stall stream while held
	assign beat          = code_wr.valid && code_wr.ready;

	always_ff @(posedge clk_sys) begin
		if (beat) rec[code_wr.addr] <= code_wr.data;
	end

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			state <= ST_COLLECT;
		end else begin
			case (state)
				ST_COLLECT: if (beat && code_wr.addr == LAST_OFS) state <= ST_HOLD;
				ST_HOLD:    if (code_ready) state <= ST_COLLECT;
				default:    state <= ST_COLLECT;
			endcase
		end
	end

	// ============================================================
	// Record output
	// ============================================================

	assign code_valid = (state == ST_HOLD);

	// Lowest offset is the least significant byte of each field
	assign code_flags   = {rec[3], rec[2], rec[1], rec[0]};
	assign code_addr    = {rec[7], rec[6], rec[5], rec[4]};
	assign code_compare = {rec[11], rec[10], rec[9], rec[8]};
	assign code_replace = {rec[15], rec[14], rec[13], rec[12]};

	// Held record stays valid and unchanged until taken
	a_code_hold : assert property (@(posedge clk_sys) disable iff (rst)
		code_valid && !code_ready |=> code_valid
			&& $stable({code_flags, code_addr, code_compare, code_replace}));

endmodule

/* logic/download_router.sv */
module download_router import loader_pkg::*; #(
	parameter int ROM_ADDR_W = 13
) (
	input  logic     clk_sys,
	input  logic     rst,
	input  logic     dl_active,
	input  index_t   dl_index,
	input  logic     dl_valid,
	output logic     dl_ready,
	input  dl_addr_t dl_addr,
	input  byte_t    dl_data,
	byte_wr_if.source cart_wr,
	byte_wr_if.source code_wr,
	output logic     cart_beat,
	output dl_addr_t beat_addr,
	output logic     handheld
);
	localparam int OFS_W = $clog2(CODE_BYTES);

	logic                  code_sel;
	logic                  active_q;
	logic                  dl_start;
	logic [ROM_ADDR_W-1:0] wr_addr;
	logic [ROM_ADDR_W-1:0] wr_addr_cur;

	// ============================================================
	// Sink selection
	// ============================================================

	assign code_sel = (dl_index == CODE_INDEX);
	assign dl_ready = code_sel ? code_wr.ready : cart_wr.ready;  // No added cycle

	assign cart_wr.valid = dl_valid && dl_active && !code_sel;
	assign cart_wr.addr  = wr_addr_cur;
	assign cart_wr.data  = dl_data;

	assign code_wr.valid = dl_valid && dl_active && code_sel;
	assign code_wr.addr  = dl_addr[OFS_W-1:0];  // Byte within the record
	assign code_wr.data  = dl_data;

	// ============================================================
	// ROM write address
	// ============================================================

	// First byte may arrive on the same cycle dl_active rises
	assign dl_start    = dl_active && !active_q;
	assign wr_addr_cur = dl_start ? '0 : wr_addr;

	assign cart_beat = cart_wr.valid && cart_wr.ready;
	assign beat_addr = dl_addr;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			active_q <= 1'b0;
			wr_addr  <= '0;
			handheld <= 1'b0;
		end else begin
			active_q <= dl_active;
			if (cart_beat) begin
				wr_addr  <= wr_addr_cur + 1'b1;
				handheld <= (dl_index[4:0] == HANDHELD_INDEX);
			end else if (dl_start) begin
				wr_addr <= '0;
			end
		end
	end

	// Stalled cartridge beat keeps its address and byte
	a_cart_hold : assert property (@(posedge clk_sys) disable iff (rst)
		(cart_wr.valid && !cart_wr.ready) ##1 cart_wr.valid
			|-> $stable(cart_wr.addr) && $stable(cart_wr.data));

endmodule

/* logic/loader_if.sv */
// Byte write channel, valid/ready
interface byte_wr_if import loader_pkg::*; #(
	parameter int ADDR_W = 13
) ();
	logic              valid;
	logic              ready;
	logic [ADDR_W-1:0] addr;
	byte_t             data;

	modport source (
		output valid, addr, data,
		input  ready
	);

	modport sink (
		input  valid, addr, data,
		output ready
	);
endinterface

// ROM read channel, fixed latency
interface rom_rd_if import loader_pkg::*; #(
	parameter int ADDR_W = 13
) ();
	logic              req;
	logic [ADDR_W-1:0] addr;
	byte_t             data;
	logic              data_valid;  // One cycle after req

	modport master (output req, addr, input data, data_valid);
	modport slave (input req, addr, output data, data_valid);
endinterface

/* logic/loader_pkg.sv */
package loader_pkg;

	// ============================================================
	// Data widths
	// ============================================================

	typedef logic [7:0]  byte_t;     // Stream and ROM byte
	typedef logic [31:0] word_t;     // One cheat record field
	typedef logic [7:0]  index_t;    // Download type
	typedef logic [24:0] dl_addr_t;  // Download byte address

	// ============================================================
	// Download types
	// ============================================================

	// Cheat download uses the all-ones index
	localparam index_t CODE_INDEX = 8'hFF;

	// Low index bits of a handheld cartridge
	localparam logic [4:0] HANDHELD_INDEX = 5'd2;

	// ============================================================
	// Cartridge and cheat layout
	// ============================================================

	// Optional copier header in front of the ROM image
	localparam int HEADER_BYTES = 512;

	// Flags, address, compare, replace; four bytes each
	localparam int CODE_BYTES = 16;

endpackage

/* logic/loader_top.sv */
module loader_top import loader_pkg::*; #(
	parameter int ROM_ADDR_W = 13,
	parameter int WRITE_WAIT = 3
) (
	input  logic                  clk_sys,
	input  logic                  rst,

	// Download stream
	input  logic                  dl_active,
	input  index_t                dl_index,
	input  logic                  dl_valid,
	output logic                  dl_ready,
	input  dl_addr_t              dl_addr,
	input  byte_t                 dl_data,

	// Console ROM reads
	input  logic                  rd_req,
	input  logic [ROM_ADDR_W-1:0] rd_addr,
	output byte_t                 rd_data,
	output logic                  rd_data_valid,

	// Cheat records
	output logic                  code_valid,
	input  logic                  code_ready,
	output word_t                 code_flags,
	output word_t                 code_addr,
	output word_t                 code_compare,
	output word_t                 code_replace,

	output logic                  handheld
);
	localparam int OFS_W = $clog2(CODE_BYTES);

	logic     cart_beat;
	dl_addr_t beat_addr;

	byte_wr_if #(.ADDR_W(ROM_ADDR_W)) cart_wr ();
	byte_wr_if #(.ADDR_W(OFS_W))      code_wr ();
	rom_rd_if  #(.ADDR_W(ROM_ADDR_W)) rom_rd ();

	// ============================================================
	// Download side
	// ============================================================

	download_router #(.ROM_ADDR_W(ROM_ADDR_W)) u_router (
		.clk_sys   (clk_sys),
		.rst       (rst),
		.dl_active (dl_active),
		.dl_index  (dl_index),
		.dl_valid  (dl_valid),
		.dl_ready  (dl_ready),
		.dl_addr   (dl_addr),
		.dl_data   (dl_data),
		.cart_wr   (cart_wr),
		.code_wr   (code_wr),
		.cart_beat (cart_beat),
		.beat_addr (beat_addr),
		.handheld  (handheld)
	);

	cheat_assembler u_cheat (
		.clk_sys      (clk_sys),
		.rst          (rst),
		.code_wr      (code_wr),
		.code_valid   (code_valid),
		.code_ready   (code_ready),
		.code_flags   (code_flags),
		.code_addr    (code_addr),
		.code_compare (code_compare),
		.code_replace (code_replace)
	);

	// ============================================================
	// Cartridge ROM
	// ============================================================

	cart_geometry #(.ROM_ADDR_W(ROM_ADDR_W)) u_geometry (
		.clk_sys   (clk_sys),
		.rst       (rst),
		.dl_active (dl_active),
		.cart_beat (cart_beat),
		.beat_addr (beat_addr),
		.rd_req    (rd_req),
		.rd_addr   (rd_addr),
		.rom_rd    (rom_rd)
	);

	rom_store #(
		.ROM_ADDR_W (ROM_ADDR_W),
		.WRITE_WAIT (WRITE_WAIT)
	) u_rom (
		.clk_sys (clk_sys),
		.rst     (rst),
		.cart_wr (cart_wr),
		.rom_rd  (rom_rd)
	);

	assign rd_data       = rom_rd.data;
	assign rd_data_valid = rom_rd.data_valid;  // Two cycles after rd_req

endmodule

/* logic/rom_store.sv */
module rom_store import loader_pkg::*; #(
	parameter int ROM_ADDR_W = 13,
	parameter int WRITE_WAIT = 3
) (
	input  logic    clk_sys,
	input  logic    rst,
	byte_wr_if.sink cart_wr,
	rom_rd_if.slave rom_rd
);
	localparam int DEPTH = 2 ** ROM_ADDR_W;
	localparam int CNT_W = $clog2(WRITE_WAIT + 2);

	byte_t            mem [DEPTH];
	logic [CNT_W-1:0] busy_cnt;  // Remaining write slot cycles
	logic             wr_fire;

	// ============================================================
	// Write port
	// ============================================================

	assign cart_wr.ready = (busy_cnt == '0);
	assign wr_fire       = cart_wr.valid && cart_wr.ready;

	always_ff @(posedge clk_sys) begin
		if (rst)
			busy_cnt <= '0;
		else if (wr_fire)
			busy_cnt <= CNT_W'(WRITE_WAIT);
		else if (busy_cnt != '0)
			busy_cnt <= busy_cnt - 1'b1;
	end

	always_ff @(posedge clk_sys) begin
		if (wr_fire) mem[cart_wr.addr] <= cart_wr.data;
	end

	// ============================================================
	// Read port
	// ============================================================

	always_ff @(posedge clk_sys) begin
		if (rom_rd.req) rom_rd.data <= mem[rom_rd.addr];
	end

	always_ff @(posedge clk_sys) begin
		if (rst)
			rom_rd.data_valid <= 1'b0;
		else
			rom_rd.data_valid <= rom_rd.req;
	end

	// Each accepted write blocks the port for the whole slot
	a_write_slot : assert property (@(posedge clk_sys) disable iff (rst)
		wr_fire |=> !cart_wr.ready [*WRITE_WAIT]);

endmodule

/* project.f */
logic/loader_pkg.sv
logic/loader_if.sv
logic/download_router.sv
logic/cart_geometry.sv
logic/cheat_assembler.sv
logic/rom_store.sv
logic/loader_top.sv
bench/tb_loader.sv

/* run.sh */
#!/bin/sh
# Build the loader testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module tb_loader -f project.f -o tb_loader \
	|| { echo "Verilator build failed"; exit 1; }

./obj_dir/tb_loader > sim.log 2>&1 || echo "Simulator exited with an error" >> sim.log
cat sim.log

grep -q "Something failed" sim.log && exit 1
grep -q "Everything OK" sim.log || exit 1
exit 0
